/* project.f */
+incdir+verilog
+incdir+sim
verilog/zx_pkg.sv
verilog/mem_req_if.sv
verilog/page_ctrl.sv
verilog/tape_fetch.sv
verilog/mem_arbiter.sv
verilog/mem_store.sv
verilog/zx_mem_top.sv
sim/tb_zx_mem.sv

/* Makefile */
# Verilator build and run of the memory subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_zx_mem
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh sim/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/tb_tasks.svh */
// Testbench tasks: value check, map model, handshake drivers and the six directed tests
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

task automatic check(input logic [7:0] actual, input logic [7:0] expected, input string msg);
	if (actual !== expected) begin
		$display("[FAIL] %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
		$display("STATUS: FAIL");
		$fatal(1, "value mismatch");
	end
endtask

// ==========================================================================
// 128K map model
// ==========================================================================

function automatic logic [17:0] ram_base(input logic [2:0] page);
	ram_base = 18'(page) * 18'h04000;
endfunction

function automatic logic [17:0] map_addr(input logic [15:0] a);
	logic [17:0] off;
	off = {4'b0000, a[13:0]};
	case (a[15:14])
		// ROM bank from bit 4 of the paging byte
		2'b00:   map_addr = `ZX_ROM_BASE + (page_model[4] ? 18'h04000 : 18'h00000) + off;
		2'b01:   map_addr = ram_base(3'd5) + off;
		2'b10:   map_addr = ram_base(3'd2) + off;
		default: map_addr = ram_base(page_model[2:0]) + off;
	endcase
endfunction

// ==========================================================================
// Handshake drivers
// ==========================================================================

task automatic apply_reset();
	reset = 1'b1;
	repeat (3) @(posedge clk_sys);
	@(negedge clk_sys);
	reset      = 1'b0;
	page_model = 8'h00;
	tape_pos   = 0;
endtask

task automatic cpu_access(input logic io, input logic we, input logic [15:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
	cpu_io    = io;
	cpu_we    = we;
	cpu_addr  = addr;
	cpu_wdata = wdata;
	cpu_req   = 1'b1;
	do @(negedge clk_sys); while (!cpu_ack);
	rdata   = cpu_rdata;
	cpu_req = 1'b0;
	do @(negedge clk_sys); while (cpu_ack);
endtask

task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
	logic [7:0] d;
	cpu_access(1'b0, 1'b1, addr, data, d);
	// Writes to ROM in slot 0 are dropped
	if (addr[15:14] != 2'b00)
		ref_mem[map_addr(addr)] = data;
endtask

task automatic cpu_read_check(input logic [15:0] addr, input string msg);
	logic [7:0] d;
	cpu_access(1'b0, 1'b0, addr, 8'h00, d);
	check(d, ref_mem[map_addr(addr)], msg);
endtask

task automatic page_write(input logic [7:0] data);
	logic [7:0] d;
	cpu_access(1'b1, 1'b1, 16'h7FFD, data, d);
	if (!page_model[5])
		page_model = data;
endtask

task automatic load_write(input logic [17:0] addr, input logic [7:0] data);
	load_addr = addr;
	load_data = data;
	load_req  = 1'b1;
	do @(negedge clk_sys); while (!load_ack);
	load_req = 1'b0;
	do @(negedge clk_sys); while (load_ack);
	ref_mem[addr] = data;
endtask

task automatic tape_read_check(input string msg);
	logic [7:0] d;
	tape_req = 1'b1;
	do @(negedge clk_sys); while (!tape_ack);
	d        = tape_data;
	tape_req = 1'b0;
	do @(negedge clk_sys); while (tape_ack);
	check(d, ref_mem[`ZX_TAPE_BASE + 18'(tape_pos)], msg);
	tape_pos++;
endtask

// ==========================================================================
// Directed tests
// ==========================================================================

task automatic test_default_map();
	logic [7:0] d;
	load_write(`ZX_ROM_BASE, 8'hA0);
	load_write(ram_base(3'd5), 8'hB5);
	load_write(ram_base(3'd2), 8'hC2);
	load_write(ram_base(3'd0), 8'hD0);
	cpu_read_check(16'h0000, "default map slot 0");
	cpu_read_check(16'h4000, "default map slot 1");
	cpu_read_check(16'h8000, "default map slot 2");
	cpu_read_check(16'hC000, "default map slot 3");
	// Floating bus on an I/O read
	cpu_access(1'b1, 1'b0, 16'h7FFD, 8'h00, d);
	check(d, 8'hFF, "I/O read of 7FFD");
endtask

task automatic test_top_page();
	for (int p = 0; p < 8; p++) begin
		page_write(8'(p));
		cpu_write(16'hC123, 8'(8'h30 + p));
		// Marker placed straight into physical bank p
		load_write(ram_base(3'(p)) + 18'h00124, 8'(8'h50 + p));
	end
	for (int p = 0; p < 8; p++) begin
		page_write(8'(p));
		cpu_read_check(16'hC123, $sformatf("slot 3 read with page %0d", p));
		cpu_read_check(16'hC124, $sformatf("loader byte in page %0d", p));
	end
endtask

task automatic test_rom_select();
	load_write(`ZX_ROM_BASE + 18'h04000, 8'hE1);
	load_write(`ZX_ROM_BASE + 18'h04100, 8'hE2);
	page_write(8'h10);
	cpu_read_check(16'h0000, "ROM bank 1 at 0x0000");
	cpu_write(16'h0100, 8'h5A);
	cpu_read_check(16'h0100, "ROM byte after CPU write");
endtask

task automatic test_lock();
	page_write(8'h31);
	// Would select ROM 0 and page 4 if paging were not locked
	page_write(8'h04);
	cpu_read_check(16'hC123, "slot 3 stays on page 1 when locked");
	cpu_read_check(16'h0000, "ROM bank 1 kept when locked");
	apply_reset();
	cpu_read_check(16'h0000, "ROM bank 0 after reset");
	cpu_read_check(16'hC123, "page 0 after reset");
endtask

task automatic test_tape();
	for (int i = 0; i < 16; i++)
		load_write(`ZX_TAPE_BASE + 18'(i), 8'($urandom));
	for (int i = 0; i < 6; i++)
		tape_read_check($sformatf("tape byte %0d", i));
	tape_rewind = 1'b1;
	@(negedge clk_sys);
	tape_rewind = 1'b0;
	tape_pos    = 0;
	for (int i = 0; i < 4; i++)
		tape_read_check($sformatf("tape byte %0d after rewind", i));
endtask

task automatic test_contention();
	fork
		begin : cpu_side
			logic [15:0] a;
			for (int i = 0; i < 8; i++) begin
				repeat ($urandom % 4) @(negedge clk_sys);
				a = 16'h8000 | 16'($urandom % 16384);
				cpu_write(a, 8'($urandom));
				cpu_read_check(a, $sformatf("contention CPU read at %h", a));
			end
		end
		begin : tape_side
			for (int i = 0; i < 8; i++) begin
				repeat ($urandom % 3) @(negedge clk_sys);
				tape_read_check($sformatf("contention tape read %0d", i));
			end
		end
		// Loader fills RAM 3 away from the CPU and tape regions
		begin : load_side
			for (int i = 0; i < 8; i++) begin
				repeat ($urandom % 4) @(negedge clk_sys);
				load_write(ram_base(3'd3) + 18'(i * 65), 8'($urandom));
			end
		end
	join
	page_write(8'h03);
	for (int i = 0; i < 8; i++)
		cpu_read_check(16'hC000 + 16'(i * 65), "loader byte seen through slot 3");
endtask

`endif

/* sim/tb_zx_mem.sv */
// Testbench top for the memory subsystem: clock, reset, watchdog, DUT and test sequence
`timescale 1ns/100ps
`default_nettype none

`include "zx_defs.svh"

module tb_zx_mem;

	// Handshakes in the map, paging, ROM, lock, tape and contention tests
	localparam int HS_TOTAL = 9 + 48 + 6 + 6 + 26 + 41;
	localparam int HS_TIME  = 200;

	logic        clk_sys;
	logic        reset;
	logic        cpu_req;
	logic        cpu_we;
	logic        cpu_io;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_wdata;
	logic        cpu_ack;
	logic [7:0]  cpu_rdata;
	logic        load_req;
	logic [17:0] load_addr;
	logic [7:0]  load_data;
	logic        load_ack;
	logic        tape_req;
	logic        tape_rewind;
	logic        tape_ack;
	logic [7:0]  tape_data;

	// Reference model of physical memory, paging byte and tape position
	logic [7:0]  ref_mem [1 << `ZX_PADDR_W];
	logic [7:0]  page_model;
	int          tape_pos;

	zx_mem_top dut_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cpu_req     (cpu_req),
		.cpu_we      (cpu_we),
		.cpu_io      (cpu_io),
		.cpu_addr    (cpu_addr),
		.cpu_wdata   (cpu_wdata),
		.cpu_ack     (cpu_ack),
		.cpu_rdata   (cpu_rdata),
		.load_req    (load_req),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.load_ack    (load_ack),
		.tape_req    (tape_req),
		.tape_rewind (tape_rewind),
		.tape_ack    (tape_ack),
		.tape_data   (tape_data)
	);

	`include "tb_tasks.svh"

	// ==========================================================================
	// Clock and watchdog
	// ==========================================================================

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	initial begin
		#(HS_TOTAL * HS_TIME);
		$display("Watchdog expired: a handshake never completed");
		$display("STATUS: FAIL");
		$fatal(1, "simulation timed out");
	end

	// ==========================================================================
	// Test sequence
	// ==========================================================================

	initial begin
		void'($urandom(32'hfcda));
		reset       = 1'b1;
		cpu_req     = 1'b0;
		cpu_we      = 1'b0;
		cpu_io      = 1'b0;
		cpu_addr    = 16'h0000;
		cpu_wdata   = 8'h00;
		load_req    = 1'b0;
		load_addr   = 18'h00000;
		load_data   = 8'h00;
		tape_req    = 1'b0;
		tape_rewind = 1'b0;
		apply_reset();
		test_default_map();
		test_top_page();
		test_rom_select();
		test_lock();
		test_tape();
		test_contention();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/zx_mem_top.sv */
// Memory subsystem top: CPU pager, tape reader, loader port, arbiter and store
`timescale 1ns/100ps
`default_nettype none

module zx_mem_top import zx_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cpu_req,
	input  logic        cpu_we,
	input  logic        cpu_io,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_wdata,
	output logic        cpu_ack,
	output logic [7:0]  cpu_rdata,
	input  logic        load_req,
	input  paddr_t      load_addr,
	input  logic [7:0]  load_data,
	output logic        load_ack,
	input  logic        tape_req,
	input  logic        tape_rewind,
	output logic        tape_ack,
	output logic [7:0]  tape_data
);

	mem_req_if cpu_ch ();
	mem_req_if tape_ch ();
	mem_req_if load_ch ();
	mem_req_if mem_ch ();

	// Image loader writes physical addresses, never reads
	assign load_ch.req   = load_req;
	assign load_ch.we    = 1'b1;
	assign load_ch.addr  = load_addr;
	assign load_ch.wdata = load_data;
	assign load_ack      = load_ch.ack;

	page_ctrl page_ctrl_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_req   (cpu_req),
		.cpu_we    (cpu_we),
		.cpu_io    (cpu_io),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.mem       (cpu_ch.requester)
	);

	tape_fetch tape_fetch_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.tape_req    (tape_req),
		.tape_rewind (tape_rewind),
		.tape_ack    (tape_ack),
		.tape_data   (tape_data),
		.mem         (tape_ch.requester)
	);

	mem_arbiter mem_arbiter_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.load_ch (load_ch.responder),
		.tape_ch (tape_ch.responder),
		.cpu_ch  (cpu_ch.responder),
		.mem_ch  (mem_ch.requester)
	);

	mem_store mem_store_i (
		.clk_sys (clk_sys),
		.reset   (reset),
		.mem     (mem_ch.responder)
	);

endmodule

`default_nettype wire

/* verilog/mem_store.sv */
// Shared byte store with fixed access latency behind a four-phase channel
`timescale 1ns/100ps
`default_nettype none

`include "zx_defs.svh"

module mem_store (
	input  logic         clk_sys,
	input  logic         reset,
	mem_req_if.responder mem
);

	localparam int MEM_DEPTH = 1 << `ZX_PADDR_W;
	localparam int CNT_W     = $clog2(`ZX_MEM_LATENCY) + 1;

	logic [7:0]       mem_array [MEM_DEPTH];
	logic             busy;
	logic             ack;
	logic [CNT_W-1:0] wait_cnt;
	logic [7:0]       rdata;

	assign mem.ack   = ack;
	assign mem.rdata = rdata;

	// Access counter and ack
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			busy     <= 1'b0;
			ack      <= 1'b0;
			wait_cnt <= '0;
		end else if (ack) begin
			if (!mem.req)
				ack <= 1'b0;
		end else if (busy) begin
			if (wait_cnt == '0) begin
				busy <= 1'b0;
				ack  <= 1'b1;
			end else begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end else if (mem.req) begin
			busy     <= 1'b1;
			wait_cnt <= CNT_W'(`ZX_MEM_LATENCY - 1);
		end
	end

	// Array access happens when the request is accepted
	always_ff @(posedge clk_sys) begin
		if (!busy && !ack && mem.req) begin
			if (mem.we)
				mem_array[mem.addr] <= mem.wdata;
			else
				rdata <= mem_array[mem.addr];
		end
	end

endmodule

`default_nettype wire

/* verilog/mem_arbiter.sv */
// Fixed-priority arbiter: loader over tape over CPU onto one memory channel
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter (
	input  logic         clk_sys,
	input  logic         reset,
	mem_req_if.responder load_ch,
	mem_req_if.responder tape_ch,
	mem_req_if.responder cpu_ch,
	mem_req_if.requester mem_ch
);

	// One-hot grant bit positions
	localparam int G_LOAD = 2;
	localparam int G_TAPE = 1;
	localparam int G_CPU  = 0;

	logic [2:0] grant;
	logic [2:0] reqs;
	logic       granted_req;

	assign reqs        = {load_ch.req, tape_ch.req, cpu_ch.req};
	assign granted_req = |(grant & reqs);

	// ==========================================================================
	// Grant state
	// ==========================================================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			grant <= 3'b000;
		end else if (grant == 3'b000) begin
			if (reqs[G_LOAD])
				grant <= 3'b100;
			else if (reqs[G_TAPE])
				grant <= 3'b010;
			else if (reqs[G_CPU])
				grant <= 3'b001;
		end else if (!granted_req && !mem_ch.ack) begin
			// Channel back at idle on both sides
			grant <= 3'b000;
		end
	end

	// ==========================================================================
	// Request routing
	// ==========================================================================

	always_comb begin
		mem_ch.req   = 1'b0;
		mem_ch.we    = 1'b0;
		mem_ch.addr  = cpu_ch.addr;
		mem_ch.wdata = cpu_ch.wdata;
		if (grant[G_LOAD]) begin
			mem_ch.req   = load_ch.req;
			mem_ch.we    = load_ch.we;
			mem_ch.addr  = load_ch.addr;
			mem_ch.wdata = load_ch.wdata;
		end else if (grant[G_TAPE]) begin
			mem_ch.req   = tape_ch.req;
			mem_ch.we    = tape_ch.we;
			mem_ch.addr  = tape_ch.addr;
			mem_ch.wdata = tape_ch.wdata;
		end else if (grant[G_CPU]) begin
			mem_ch.req   = cpu_ch.req;
			mem_ch.we    = cpu_ch.we;
			mem_ch.addr  = cpu_ch.addr;
			mem_ch.wdata = cpu_ch.wdata;
		end
	end

	// Response goes back to the granted peer only
	assign load_ch.ack   = grant[G_LOAD] & mem_ch.ack;
	assign tape_ch.ack   = grant[G_TAPE] & mem_ch.ack;
	assign cpu_ch.ack    = grant[G_CPU] & mem_ch.ack;
	assign load_ch.rdata = grant[G_LOAD] ? mem_ch.rdata : 8'h00;
	assign tape_ch.rdata = grant[G_TAPE] ? mem_ch.rdata : 8'h00;
	assign cpu_ch.rdata  = grant[G_CPU] ? mem_ch.rdata : 8'h00;

endmodule

`default_nettype wire

/* verilog/tape_fetch.sv */
// Tape buffer reader: read pointer into the tape area and tape handshake
`timescale 1ns/100ps
`default_nettype none

`include "zx_defs.svh"

module tape_fetch import zx_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         tape_req,
	input  logic         tape_rewind,
	output logic         tape_ack,
	output logic [7:0]   tape_data,
	mem_req_if.requester mem
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_MEM  = 2'd1;
	localparam logic [1:0] ST_ACK  = 2'd2;

	logic [1:0] state;
	logic       mem_req;
	paddr_t     tape_ptr;

	// Read only channel
	assign mem.req   = mem_req;
	assign mem.we    = 1'b0;
	assign mem.addr  = tape_ptr;
	assign mem.wdata = 8'h00;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state    <= ST_IDLE;
			tape_ack <= 1'b0;
			mem_req  <= 1'b0;
			tape_ptr <= `ZX_TAPE_BASE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (tape_req) begin
						mem_req <= 1'b1;
						state   <= ST_MEM;
					end else if (tape_rewind) begin
						tape_ptr <= `ZX_TAPE_BASE;
					end
				end
				ST_MEM: if (mem.ack) begin
					mem_req  <= 1'b0;
					tape_ack <= 1'b1;
					state    <= ST_ACK;
				end
				default: if (!tape_req && !mem.ack) begin
					tape_ack <= 1'b0;
					state    <= ST_IDLE;
					// Step to the next byte, wrap at the end of the image area
					if (tape_ptr == `ZX_TAPE_LAST)
						tape_ptr <= `ZX_TAPE_BASE;
					else
						tape_ptr <= tape_ptr + 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == ST_MEM && mem.ack)
			tape_data <= mem.rdata;
	end

endmodule

`default_nettype wire

/* verilog/page_ctrl.sv */
// CPU side: 7FFD paging register, logical to physical map and CPU handshake
`timescale 1ns/100ps
`default_nettype none

`include "zx_defs.svh"

module page_ctrl import zx_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         cpu_req,
	input  logic         cpu_we,
	input  logic         cpu_io,
	input  logic [15:0]  cpu_addr,
	input  logic [7:0]   cpu_wdata,
	output logic         cpu_ack,
	output logic [7:0]   cpu_rdata,
	mem_req_if.requester mem
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_MEM  = 2'd1;
	localparam logic [1:0] ST_ACK  = 2'd2;

	logic [1:0] state;
	page_reg_u  page_reg;
	logic       mem_req;
	logic       port_hit;
	logic       rom_write;
	logic       local_hit;
	paddr_t     paddr;

	assign port_hit  = (cpu_addr & `ZX_PAGE_PORT_MASK) == 16'h0000;
	assign rom_write = cpu_we && (cpu_addr[15:14] == 2'b00);
	// Accesses finished here without a trip to memory
	assign local_hit = cpu_io || rom_write;

	// 16 KB slots of the 128K map
	always_comb begin
		case (cpu_addr[15:14])
			2'b00:   paddr = `ZX_ROM_BASE + paddr_t'({page_reg.f.rom_sel, cpu_addr[13:0]});
			2'b01:   paddr = {1'b0, 3'd5, cpu_addr[13:0]};
			2'b10:   paddr = {1'b0, 3'd2, cpu_addr[13:0]};
			default: paddr = {1'b0, page_reg.f.ram_page, cpu_addr[13:0]};
		endcase
	end

	assign mem.req   = mem_req;
	assign mem.we    = cpu_we;
	assign mem.addr  = paddr;
	assign mem.wdata = cpu_wdata;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= ST_IDLE;
			cpu_ack      <= 1'b0;
			mem_req      <= 1'b0;
			page_reg.raw <= 8'h00;
		end else begin
			case (state)
				ST_IDLE: if (cpu_req) begin
					if (local_hit) begin
						// Locked paging ignores further 7FFD writes until reset
						if (cpu_io && cpu_we && port_hit && !page_reg.f.lock)
							page_reg.raw <= cpu_wdata;
						cpu_ack <= 1'b1;
						state   <= ST_ACK;
					end else begin
						mem_req <= 1'b1;
						state   <= ST_MEM;
					end
				end
				ST_MEM: if (mem.ack) begin
					mem_req <= 1'b0;
					cpu_ack <= 1'b1;
					state   <= ST_ACK;
				end
				// Memory ack must be low too before the CPU may start again
				default: if (!cpu_req && !mem.ack) begin
					cpu_ack <= 1'b0;
					state   <= ST_IDLE;
				end
			endcase
		end
	end

	// Read data, floating bus on I/O
	always_ff @(posedge clk_sys) begin
		if (state == ST_IDLE && cpu_req && local_hit)
			cpu_rdata <= 8'hFF;
		else if (state == ST_MEM && mem.ack)
			cpu_rdata <= mem.rdata;
	end

endmodule

`default_nettype wire

/* verilog/mem_req_if.sv */
// Four-phase byte memory channel with requester and responder views
`timescale 1ns/100ps
`default_nettype none

interface mem_req_if import zx_pkg::*; ();

	// Request side, held stable while req is high
	logic       req;
	logic       we;
	paddr_t     addr;
	logic [7:0] wdata;

	// Response side, rdata valid while ack is high
	logic       ack;
	logic [7:0] rdata;

	modport requester (
		output req,
		output we,
		output addr,
		output wdata,
		input  ack,
		input  rdata
	);

	modport responder (
		input  req,
		input  we,
		input  addr,
		input  wdata,
		output ack,
		output rdata
	);

endinterface

`default_nettype wire

/* verilog/zx_pkg.sv */
// Types for the memory subsystem: physical address and the 7FFD paging byte
`default_nettype none

`include "zx_defs.svh"

package zx_pkg;

	// Byte address into the shared store
	typedef logic [`ZX_PADDR_W-1:0] paddr_t;

	// 7FFD fields as the 128K hardware decodes them
	typedef struct packed {
		logic [1:0] unused;
		logic       lock;
		logic       rom_sel;
		// Shadow screen select, kept but not used for memory
		logic       screen;
		logic [2:0] ram_page;
	} page_fields_t;

	// Same byte seen as data written by the CPU or as paging fields
	typedef union packed {
		logic [7:0]   raw;
		page_fields_t f;
	} page_reg_u;

endpackage

`default_nettype wire

/* verilog/zx_defs.svh */
// Memory subsystem macros: address width, region bases, store latency, 7FFD decode
`ifndef ZX_DEFS_SVH
`define ZX_DEFS_SVH

// ==========================================================================
// Physical address space
// ==========================================================================

// 256 KB byte space
`define ZX_PADDR_W        18

// Two 16 KB ROM banks above the 128 KB of RAM
`define ZX_ROM_BASE       18'h20000

// Tape image fills the rest of the space
`define ZX_TAPE_BASE      18'h28000
`define ZX_TAPE_LAST      18'h3FFFF

// ==========================================================================
// Timing and I/O decode
// ==========================================================================

// Cycles from request seen to ack in the store
`define ZX_MEM_LATENCY    2

// Paging port hit when A15 and A1 are both low
`define ZX_PAGE_PORT_MASK 16'h8002

`endif
